// File: bench/coreTb.sv
/* Testbench of the multicycle core: memory model, hand-encoded program and a
   reference interpreter that predicts every fetch address and store */
`timescale 1ns/1ps
`default_nettype none

module coreTb;
	import rvPkg::*;

	localparam logic [31:0] HaltInstr = 32'h0000_006f;

	logic clk;
	logic reset;
	logic [31:0] memAddr;
	logic [31:0] memWData;
	logic [31:0] memRData;
	logic memWrite;
	fsmStateT state;

	logic [31:0] mem [256];
	// reference copies of memory, registers and PC
	logic [31:0] gmem [256];
	logic [31:0] gr [32];
	logic [31:0] gpc;
	logic storeDue;
	logic [31:0] storeAddr;
	logic [31:0] storeData;
	integer seed;
	integer progLen;
	integer steps;
	logic halted;

	rv32Core #(.ResetPc(32'h0000_0000)) rv32Core_i (
		.clk(clk),
		.reset(reset),
		.memAddr(memAddr),
		.memWData(memWData),
		.memWrite(memWrite),
		.memRData(memRData),
		.state(state)
	);

	always #4 clk = ~clk;

	assign memRData = mem[memAddr[9:2]];

	always @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr[9:2]] <= memWData;
		end
	end

	function automatic logic [31:0] encR(input logic f7b5, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] w);
		mem[progLen] = w;
		gmem[progLen] = w;
		progLen = progLen + 1;
	endtask

	task automatic buildProgram;
		integer i;
		logic [31:0] rnd;
		logic [11:0] offset;
		for (i = 0; i < 256; i = i + 1) begin
			mem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0003);
			gmem[i] = mem[i];
		end
		// random operands through an ADDI chain
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011));
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd0, 3'b000, 5'd2, 7'b0010011));
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd1, 3'b000, 5'd3, 7'b0010011));
		emit(encR(1'b0, 5'd2, 5'd1, 3'b000, 5'd4));
		emit(encR(1'b1, 5'd3, 5'd1, 3'b000, 5'd5));
		emit(encR(1'b0, 5'd3, 5'd2, 3'b111, 5'd6));
		emit(encR(1'b0, 5'd2, 5'd1, 3'b110, 5'd7));
		emit(encR(1'b0, 5'd2, 5'd1, 3'b010, 5'd8));
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd3, 3'b010, 5'd9, 7'b0010011));
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd2, 3'b111, 5'd10, 7'b0010011));
		rnd = $random(seed);
		emit(encI(rnd[11:0], 5'd1, 3'b110, 5'd11, 7'b0010011));
		emit(encI(12'd512, 5'd0, 3'b000, 5'd20, 7'b0010011));
		offset = 12'd0;
		for (i = 4; i <= 11; i = i + 1) begin
			emit(encS(offset, i[4:0], 5'd20));
			offset = offset + 12'd4;
		end
		// load back a stored word and use it
		emit(encI(12'd4, 5'd20, 3'b010, 5'd12, 7'b0000011));
		emit(encR(1'b0, 5'd1, 5'd12, 3'b000, 5'd13));
		emit(encS(12'd32, 5'd13, 5'd20));
		emit(encB(13'd8, 5'd1, 5'd1));
		emit(encI(12'd1, 5'd0, 3'b000, 5'd14, 7'b0010011));
		emit(encB(13'd8, 5'd2, 5'd1));
		emit(encI(12'd7, 5'd0, 3'b000, 5'd15, 7'b0010011));
		emit(encJ(21'd8, 5'd16));
		emit(encI(12'd3, 5'd0, 3'b000, 5'd17, 7'b0010011));
		emit(encS(12'd36, 5'd16, 5'd20));
		emit(encS(12'd40, 5'd15, 5'd20));
		emit(HaltInstr);
	endtask

	// executes the instruction at gpc by the ISA rules
	task automatic stepGolden;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] immI;
		logic [31:0] nextPc;
		logic [31:0] loadAddr;
		logic writeRd;
		ins = gmem[gpc[9:2]];
		a = gr[ins[19:15]];
		b = gr[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		nextPc = gpc + 32'd4;
		writeRd = 1'b1;
		res = 32'b0;
		case (ins[6:0])
			rType, iTypeLogic: begin
				if (ins[6:0] == iTypeLogic) begin
					b = immI;
				end
				case (ins[14:12])
					3'b000: res = (ins[6:0] == rType && ins[30]) ? a - b : a + b;
					3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			iTypeLoad: begin
				loadAddr = a + immI;
				res = gmem[loadAddr[9:2]];
			end
			sType: begin
				writeRd = 1'b0;
				storeDue = 1'b1;
				storeAddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				storeData = b;
				gmem[storeAddr[9:2]] = b;
			end
			bType: begin
				writeRd = 1'b0;
				if (a == b) begin
					nextPc = gpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			default: begin
				res = gpc + 32'd4;
				nextPc = gpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
		endcase
		if (writeRd && ins[11:7] != 5'd0) begin
			gr[ins[11:7]] = res;
		end
		gpc = nextPc;
	endtask

	task automatic awaitFetch;
		integer n;
		n = 0;
		do begin
			@(negedge clk);
			n = n + 1;
		end while (state != fetch && n < 8);
		assert (state == fetch) else begin
			$display("timeout: core stopped reaching fetch");
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// every store seen on the port must be the predicted one
	always @(negedge clk) begin
		if (!reset && memWrite) begin
			assert (storeDue) else begin
				$display("unexpected store to address %h", memAddr);
				$display("ERRORS FOUND");
				$fatal(1);
			end
			assert (memAddr === storeAddr) else begin
				$display("MISMATCH memAddr got %h expected %h", memAddr, storeAddr);
				$display("ERRORS FOUND");
				$fatal(1);
			end
			assert (memWData === storeData) else begin
				$display("MISMATCH memWData got %h expected %h", memWData, storeData);
				$display("ERRORS FOUND");
				$fatal(1);
			end
			storeDue = 1'b0;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		seed = 32'ha73f_b97d;
		storeDue = 1'b0;
		storeAddr = 32'b0;
		storeData = 32'b0;
		progLen = 0;
		steps = 0;
		halted = 1'b0;
		gpc = 32'b0;
		for (int i = 0; i < 32; i++) begin
			gr[i] = 32'b0;
		end
		buildProgram();
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		assert (state == fetch && memWrite == 1'b0) else begin
			$display("core not in fetch with store idle after reset");
			$display("ERRORS FOUND");
			$fatal(1);
		end
		while (!halted) begin
			assert (memAddr === gpc) else begin
				$display("MISMATCH memAddr got %h expected %h", memAddr, gpc);
				$display("ERRORS FOUND");
				$fatal(1);
			end
			assert (!storeDue) else begin
				$display("predicted store never appeared on the memory port");
				$display("ERRORS FOUND");
				$fatal(1);
			end
			assert (steps < 64) else begin
				$display("program did not reach its halt loop");
				$display("ERRORS FOUND");
				$fatal(1);
			end
			if (gmem[gpc[9:2]] == HaltInstr) begin
				halted = 1'b1;
			end else begin
				stepGolden();
				steps = steps + 1;
				awaitFetch();
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/rv32Core_chk.sv
/* Protocol assertions on the core's memory port and sequencer, bound into
   rv32Core from the testbench side */
`timescale 1ns/1ps
`default_nettype none

module rv32Core_chk (
	input wire logic clk,
	input wire logic reset,
	input wire rvPkg::fsmStateT state,
	input wire logic memWe,
	input wire logic [31:0] memAddr
);
	import rvPkg::*;

	// cycles spent since the last fetch state
	logic [2:0] sinceFetch;

	always_ff @(posedge clk) begin
		if (reset || state == fetch) begin
			sinceFetch <= (reset) ? 3'd0 : 3'd1;
		end else begin
			sinceFetch <= sinceFetch + 3'd1;
		end
	end

	storeOnlyInMemWrite: assert property (@(posedge clk) disable iff (reset)
		memWe |-> state == memWrite)
		else $error("memory write strobe outside the memWrite state");

	fetchAligned: assert property (@(posedge clk) disable iff (reset)
		state == fetch |-> memAddr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	decodeAfterFetch: assert property (@(posedge clk) disable iff (reset)
		state == fetch |=> state == decode)
		else $error("fetch not followed by decode");

	executeAfterDecode: assert property (@(posedge clk) disable iff (reset)
		state == decode |=> state inside {executeR, executeI, uncondJump, memAdr, branchIfEq})
		else $error("decode not followed by an execute or address state");

	// LW is the longest path, five cycles in all
	fetchWithinFive: assert property (@(posedge clk) disable iff (reset)
		state != fetch |-> sinceFetch <= 3'd4)
		else $error("no return to fetch within five cycles");

endmodule

bind rv32Core rv32Core_chk rv32Core_chkI (
	.clk(clk),
	.reset(reset),
	.state(state),
	.memWe(memWrite),
	.memAddr(memAddr)
);

`default_nettype wire

// File: filelist.f
source/rvPkg.sv
source/alu.sv
source/regFile.sv
source/immExtend.sv
source/aluDecoder.sv
source/controlFsm.sv
source/multicycleDatapath.sv
source/rv32Core.sv
bench/rv32Core_chk.sv
bench/coreTb.sv

// File: run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module coreTb -f filelist.f

if ! ./obj_dir/VcoreTb > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi

// File: source/alu.sv
/* 32-bit ALU of the core with add, subtract, and, or and signed
   set-less-than, plus a zero flag for BEQ */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire logic [31:0] a,
	input wire logic [31:0] b,
	input wire rvPkg::aluOpT aluOp,
	output logic [31:0] result,
	output logic zero
);
	import rvPkg::*;

	always_comb begin
		case (aluOp)
			opAdd: result = a + b;
			opSub: result = a - b;
			opAnd: result = a & b;
			opOr: result = a | b;
			// signed compare
			opSlt: result = {31'b0, $signed(a) < $signed(b)};
			default: result = a + b;
		endcase
	end

	assign zero = (result == 32'b0);

endmodule

`default_nettype wire

// File: source/aluDecoder.sv
/* Turns the sequencer's operation class and the instruction's function
   fields into one ALU operation */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
	input wire rvPkg::aluClassT aluClass,
	input wire logic [2:0] funct3,
	input wire logic funct7b5,
	input wire logic opIsR,
	output rvPkg::aluOpT aluOp
);
	import rvPkg::*;

	logic subSel;

	// only register forms may subtract through funct7
	assign subSel = (aluClass == rFunct) && opIsR && funct7b5;

	always_comb begin
		case (aluClass)
			add: aluOp = opAdd;
			subtract: aluOp = opSub;
			default: begin
				case (funct3)
					3'b000: aluOp = subSel ? opSub : opAdd;
					3'b010: aluOp = opSlt;
					3'b110: aluOp = opOr;
					3'b111: aluOp = opAnd;
					default: aluOp = opAdd;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/controlFsm.sv
/* Moore sequencer of the multicycle core. The control word is registered
   from the next state so it lines up with the state it belongs to */
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
	input wire logic clk,
	input wire logic reset,
	input wire rvPkg::opcodeT opcode,
	output rvPkg::ctrlT ctrl,
	output rvPkg::fsmStateT state
);
	import rvPkg::*;

	fsmStateT nextState;

	// control word for one state, all fields start from zero
	function automatic ctrlT ctrlFor(input fsmStateT s);
		ctrlT c;
		c = '0;
		case (s)
			fetch: begin
				// PC+4 goes back into the PC with the instruction load
				c.irWrite = 1'b1;
				c.aluSrcA = pc;
				c.aluSrcB = four;
				c.aluClass = add;
				c.resultSrc = aluResult;
			end
			decode: begin
				// branch or jump target into aluOut ahead of time
				c.aluSrcA = oldPc;
				c.aluSrcB = immediate;
				c.aluClass = add;
			end
			executeR: begin
				c.aluSrcA = regA;
				c.aluSrcB = regB;
				c.aluClass = rFunct;
			end
			executeI: begin
				c.aluSrcA = regA;
				c.aluSrcB = immediate;
				c.aluClass = iFunct;
			end
			uncondJump: begin
				// target from decode into PC, link address computed now
				c.aluSrcA = oldPc;
				c.aluSrcB = four;
				c.aluClass = add;
				c.resultSrc = aluOut;
				c.pcUpdate = 1'b1;
			end
			memAdr: begin
				c.aluSrcA = regA;
				c.aluSrcB = immediate;
				c.aluClass = add;
			end
			memRead: begin
				c.adrSrc = 1'b1;
				c.resultSrc = aluOut;
			end
			memWrite: begin
				c.adrSrc = 1'b1;
				c.memWrite = 1'b1;
			end
			memWb: begin
				c.resultSrc = dataReg;
				c.regWrite = 1'b1;
			end
			aluWb: begin
				c.resultSrc = aluOut;
				c.regWrite = 1'b1;
			end
			branchIfEq: begin
				c.aluSrcA = regA;
				c.aluSrcB = regB;
				c.aluClass = subtract;
				c.resultSrc = aluOut;
				c.branch = 1'b1;
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	always_comb begin
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (opcode)
					rType: nextState = executeR;
					iTypeLogic: nextState = executeI;
					iTypeLoad, sType: nextState = memAdr;
					bType: nextState = branchIfEq;
					jType: nextState = uncondJump;
					// unknown opcode parks here
					default: nextState = decode;
				endcase
			end
			executeR, executeI, uncondJump: nextState = aluWb;
			memAdr: nextState = (opcode == iTypeLoad) ? memRead : memWrite;
			memRead: nextState = memWb;
			default: nextState = fetch;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch;
			ctrl <= ctrlFor(fetch);
		end else begin
			state <= nextState;
			ctrl <= ctrlFor(nextState);
		end
	end

endmodule

`default_nettype wire

// File: source/immExtend.sv
/* Immediate generator: picks the I, S, B or J layout by opcode */
`timescale 1ns/1ps
`default_nettype none

module immExtend (
	input wire logic [31:0] instr,
	input wire rvPkg::opcodeT opcode,
	output logic [31:0] imm
);
	import rvPkg::*;

	always_comb begin
		case (opcode)
			iTypeLogic, iTypeLoad: imm = {{20{instr[31]}}, instr[31:20]};
			sType: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// branch and jump offsets are in halfwords
			bType: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			jType: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/multicycleDatapath.sv
/* Datapath of the multicycle core: architectural and pipeline registers,
   operand and result muxes, and the unified memory port */
`timescale 1ns/1ps
`default_nettype none

module multicycleDatapath #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input wire logic clk,
	input wire logic reset,
	input wire rvPkg::ctrlT ctrl,
	input wire rvPkg::aluOpT aluOp,
	output rvPkg::opcodeT opcode,
	output logic [2:0] funct3,
	output logic funct7b5,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	input wire logic [31:0] memRData
);
	import rvPkg::*;

	logic [31:0] pcReg;
	logic [31:0] oldPcReg;
	logic [31:0] instrReg;
	logic [31:0] dataWord;
	logic [31:0] aReg;
	logic [31:0] bReg;
	logic [31:0] aluOutReg;

	logic [31:0] rData1;
	logic [31:0] rData2;
	logic [31:0] immExt;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluY;
	logic aluZero;
	logic [31:0] resultBus;
	logic pcWrite;

	// fetch loads the PC too, alongside the instruction
	assign pcWrite = ctrl.irWrite | ctrl.pcUpdate | (ctrl.branch & aluZero);

	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= ResetPc;
		end else if (pcWrite) begin
			pcReg <= resultBus;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.irWrite) begin
			oldPcReg <= pcReg;
			instrReg <= memRData;
		end
		// these follow their sources every cycle
		dataWord <= memRData;
		aReg <= rData1;
		bReg <= rData2;
		aluOutReg <= aluY;
	end

	assign opcode = opcodeT'(instrReg[6:0]);
	assign funct3 = instrReg[14:12];
	assign funct7b5 = instrReg[30];

	assign memAddr = ctrl.adrSrc ? aluOutReg : pcReg;
	assign memWData = bReg;

	regFile regFileI (
		.clk(clk),
		.rs1(instrReg[19:15]),
		.rs2(instrReg[24:20]),
		.rd(instrReg[11:7]),
		.wData(resultBus),
		.we(ctrl.regWrite),
		.rData1(rData1),
		.rData2(rData2)
	);

	immExtend immExtendI (
		.instr(instrReg),
		.opcode(opcode),
		.imm(immExt)
	);

	always_comb begin
		case (ctrl.aluSrcA)
			pc: srcA = pcReg;
			oldPc: srcA = oldPcReg;
			regA: srcA = aReg;
			default: srcA = pcReg;
		endcase
	end

	always_comb begin
		case (ctrl.aluSrcB)
			regB: srcB = bReg;
			immediate: srcB = immExt;
			four: srcB = 32'd4;
			default: srcB = bReg;
		endcase
	end

	alu aluI (
		.a(srcA),
		.b(srcB),
		.aluOp(aluOp),
		.result(aluY),
		.zero(aluZero)
	);

	// shared by the PC and register writeback
	always_comb begin
		case (ctrl.resultSrc)
			aluOut: resultBus = aluOutReg;
			dataReg: resultBus = dataWord;
			aluResult: resultBus = aluY;
			default: resultBus = aluOutReg;
		endcase
	end

endmodule

`default_nettype wire

// File: source/regFile.sv
/* Integer register file, two combinational reads and one clocked write;
   x0 always reads as zero */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [4:0] rd,
	input wire logic [31:0] wData,
	input wire logic we,
	output logic [31:0] rData1,
	output logic [31:0] rData2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		// writes to x0 are dropped
		if (we && rd != 5'd0) begin
			regs[rd] <= wData;
		end
	end

	assign rData1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
	assign rData2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv32Core.sv
/* Top level of the multicycle RV32I core. Memory sits outside and answers
   memRData combinationally from memAddr */
`timescale 1ns/1ps
`default_nettype none

module rv32Core #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input wire logic clk,
	input wire logic reset,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	output logic memWrite,
	input wire logic [31:0] memRData,
	output rvPkg::fsmStateT state
);
	import rvPkg::*;

	ctrlT ctrl;
	aluOpT aluOp;
	opcodeT opcode;
	logic [2:0] funct3;
	logic funct7b5;
	logic opIsR;

	// subtract via funct7 applies to register forms only
	assign opIsR = (opcode == rType);
	assign memWrite = ctrl.memWrite;

	controlFsm controlFsmI (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.ctrl(ctrl),
		.state(state)
	);

	aluDecoder aluDecoderI (
		.aluClass(ctrl.aluClass),
		.funct3(funct3),
		.funct7b5(funct7b5),
		.opIsR(opIsR),
		.aluOp(aluOp)
	);

	multicycleDatapath #(
		.ResetPc(ResetPc)
	) datapathI (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.aluOp(aluOp),
		.opcode(opcode),
		.funct3(funct3),
		.funct7b5(funct7b5),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRData(memRData)
	);

endmodule

`default_nettype wire

// File: source/rvPkg.sv
/* Shared types for the multicycle RV32I core: opcodes, FSM states,
   ALU encodings and the registered control word */
`default_nettype none

package rvPkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		rType      = 7'b0110011,
		iTypeLogic = 7'b0010011,
		iTypeLoad  = 7'b0000011,
		sType      = 7'b0100011,
		bType      = 7'b1100011,
		jType      = 7'b1101111
	} opcodeT;

	typedef enum logic [3:0] {
		fetch      = 4'd0,
		decode     = 4'd1,
		executeR   = 4'd2,
		uncondJump = 4'd3,
		executeI   = 4'd4,
		memAdr     = 4'd5,
		aluWb      = 4'd6,
		memWrite   = 4'd7,
		memRead    = 4'd8,
		memWb      = 4'd9,
		branchIfEq = 4'd10
	} fsmStateT;

	// operation class handed from the sequencer to the ALU decoder
	typedef enum logic [1:0] {
		add      = 2'b00,
		subtract = 2'b01,
		rFunct   = 2'b10,
		iFunct   = 2'b11
	} aluClassT;

	typedef enum logic [2:0] {
		opAdd = 3'b000,
		opSub = 3'b001,
		opAnd = 3'b010,
		opOr  = 3'b011,
		opSlt = 3'b101
	} aluOpT;

	typedef enum logic [1:0] {pc = 2'd0, oldPc = 2'd1, regA = 2'd2} srcAT;
	typedef enum logic [1:0] {regB = 2'd0, immediate = 2'd1, four = 2'd2} srcBT;
	typedef enum logic [1:0] {aluOut = 2'd0, dataReg = 2'd1, aluResult = 2'd2} resultSrcT;

	typedef struct packed {
		logic      adrSrc;
		logic      irWrite;
		logic      regWrite;
		logic      pcUpdate;
		logic      memWrite;
		logic      branch;
		srcAT      aluSrcA;
		srcBT      aluSrcB;
		aluClassT  aluClass;
		resultSrcT resultSrc;
	} ctrlT;

endpackage

`default_nettype wire
